// ==== soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

  // bus widths
  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;

  // one strobe bit per data byte
  parameter int STRB_W = DATA_W / 8;

  // memory map of the fixed-address targets
  // every other address falls through to the sram

  // serial port, store only
  parameter logic [ADDR_W-1:0] SERIAL_ADDR = 32'ha000_03f8;

  // clint mtime halves, load only
  parameter logic [ADDR_W-1:0] RTC_ADDR_LO = 32'ha000_0048;
  parameter logic [ADDR_W-1:0] RTC_ADDR_HI = 32'ha000_004c;

  // arbiter states, one per kind of access in flight
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_IFU_READ,
    ST_LSU_READ,
    ST_LSU_WRITE
  } arb_state_e;

  // decoded target of the granted access
  // encoding 2'b11 is never produced by the decoder
  typedef enum logic [1:0] {
    TGT_SRAM,
    TGT_CLINT,
    TGT_SERIAL
  } target_e;

endpackage

`default_nettype wire

// ==== bus_arbiter.sv ====
`default_nettype none

module bus_arbiter import soc_bus_pkg::*; (
  input  wire logic              clk,
  input  wire logic              reset_i,

  // ifu, read only
  input  wire logic [ADDR_W-1:0] ifu_araddr_i,
  input  wire logic              ifu_arvalid_i,
  output logic                   ifu_arready_o,
  output logic [DATA_W-1:0]      ifu_rdata_o,
  output logic                   ifu_rvalid_o,

  // lsu load
  input  wire logic [ADDR_W-1:0] lsu_araddr_i,
  input  wire logic              lsu_arvalid_i,
  output logic [DATA_W-1:0]      lsu_rdata_o,
  output logic                   lsu_rvalid_o,

  // lsu store
  input  wire logic [ADDR_W-1:0] lsu_awaddr_i,
  input  wire logic              lsu_awvalid_i,
  input  wire logic [DATA_W-1:0] lsu_wdata_i,
  input  wire logic [STRB_W-1:0] lsu_wstrb_i,
  input  wire logic              lsu_wvalid_i,
  output logic                   lsu_wready_o,

  // sram target
  output logic                   sram_rd_o,
  output logic                   sram_wr_o,
  output logic [ADDR_W-1:0]      sram_addr_o,
  output logic [DATA_W-1:0]      sram_wdata_o,
  output logic [STRB_W-1:0]      sram_wstrb_o,
  input  wire logic [DATA_W-1:0] sram_rdata_i,

  // clint target
  output logic                   clint_rd_o,
  output logic                   clint_hi_sel_o,
  input  wire logic [DATA_W-1:0] clint_rdata_i,
  input  wire logic              clint_rvalid_i,

  // serial target
  output logic                   serial_wr_o,
  output logic [DATA_W-1:0]      serial_data_o,
  input  wire logic              serial_done_i
);

  arb_state_e state_q;
  target_e    tgt_q;

  // low in the first cycle of an access, when the target strobe fires
  logic phase_q;
  logic issue;
  logic resp_any;

  function automatic target_e load_target(input logic [ADDR_W-1:0] addr);
    target_e tgt;
    tgt = TGT_SRAM;
    if (addr == RTC_ADDR_LO || addr == RTC_ADDR_HI) begin
      tgt = TGT_CLINT;
    end
    return tgt;
  endfunction

  function automatic target_e store_target(input logic [ADDR_W-1:0] addr);
    target_e tgt;
    tgt = TGT_SRAM;
    if (addr == SERIAL_ADDR) begin
      tgt = TGT_SERIAL;
    end
    return tgt;
  endfunction

  // lsu wins over ifu, loads checked before stores
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      tgt_q   <= TGT_SRAM;
      phase_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          phase_q <= 1'b0;
          if (lsu_arvalid_i) begin
            state_q <= ST_LSU_READ;
            tgt_q   <= load_target(lsu_araddr_i);
          end else if (lsu_awvalid_i && lsu_wvalid_i) begin
            state_q <= ST_LSU_WRITE;
            tgt_q   <= store_target(lsu_awaddr_i);
          end else if (ifu_arvalid_i) begin
            state_q <= ST_IFU_READ;
            tgt_q   <= TGT_SRAM;
          end
        end
        default: begin
          phase_q <= 1'b1;
          if (resp_any) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  assign issue = (state_q != ST_IDLE) && !phase_q;

  // target strobes, one cycle after the grant
  assign sram_rd_o   = issue && ((state_q == ST_IFU_READ) ||
                                 (state_q == ST_LSU_READ && tgt_q == TGT_SRAM));
  assign clint_rd_o  = issue && state_q == ST_LSU_READ && tgt_q == TGT_CLINT;
  assign sram_wr_o   = issue && state_q == ST_LSU_WRITE && tgt_q == TGT_SRAM;
  assign serial_wr_o = issue && state_q == ST_LSU_WRITE && tgt_q == TGT_SERIAL;

  // requesters hold address and data until served
  always_comb begin
    case (state_q)
      ST_IFU_READ:  sram_addr_o = ifu_araddr_i;
      ST_LSU_WRITE: sram_addr_o = lsu_awaddr_i;
      default:      sram_addr_o = lsu_araddr_i;
    endcase
  end

  assign sram_wdata_o   = lsu_wdata_i;
  assign sram_wstrb_o   = lsu_wstrb_i;
  assign clint_hi_sel_o = (lsu_araddr_i == RTC_ADDR_HI);
  assign serial_data_o  = lsu_wdata_i;

  // responses
  assign ifu_arready_o = issue && state_q == ST_IFU_READ;
  assign ifu_rvalid_o  = phase_q && state_q == ST_IFU_READ;
  assign lsu_rvalid_o  = phase_q && state_q == ST_LSU_READ &&
                         (tgt_q == TGT_SRAM || clint_rvalid_i);
  // sram store completes in the strobe cycle, serial store on done
  assign lsu_wready_o  = (state_q == ST_LSU_WRITE) &&
                         ((tgt_q == TGT_SRAM && !phase_q) ||
                          (tgt_q == TGT_SERIAL && phase_q && serial_done_i));

  assign resp_any = ifu_rvalid_o || lsu_rvalid_o || lsu_wready_o;

  assign ifu_rdata_o = ifu_rvalid_o ? sram_rdata_i : '0;
  assign lsu_rdata_o = !lsu_rvalid_o        ? '0 :
                       (tgt_q == TGT_CLINT) ? clint_rdata_i : sram_rdata_i;

  a_one_target: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0({sram_rd_o, sram_wr_o, clint_rd_o, serial_wr_o}));

  a_one_rvalid: assert property (@(posedge clk) disable iff (reset_i)
    !(ifu_rvalid_o && lsu_rvalid_o));

  // the clint must answer in the cycle the arbiter expects
  a_clint_latency: assert property (@(posedge clk) disable iff (reset_i)
    clint_rd_o |=> clint_rvalid_i);

endmodule

`default_nettype wire

// ==== mem_sram.sv ====
`default_nettype none

module mem_sram import soc_bus_pkg::*; #(
  parameter int SRAM_WORDS = 256
) (
  input  wire logic              clk,
  input  wire logic              rd_i,
  input  wire logic              wr_i,
  input  wire logic [ADDR_W-1:0] addr_i,
  input  wire logic [DATA_W-1:0] wdata_i,
  input  wire logic [STRB_W-1:0] wstrb_i,
  output logic [DATA_W-1:0]      rdata_o
);

  localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

  logic [DATA_W-1:0] mem_q [SRAM_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic [ADDR_W-3:0] word_addr;
  logic [IDX_W-1:0]  idx;

  // byte address to word index, wrapped to the depth
  assign word_addr = addr_i[ADDR_W-1:2];
  assign idx       = IDX_W'(word_addr % (ADDR_W-2)'(SRAM_WORDS));

  // byte-masked write
  always_ff @(posedge clk) begin
    if (wr_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // registered read, data valid the cycle after rd_i
  always_ff @(posedge clk) begin
    if (rd_i) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign rdata_o = rdata_q;

  // single port, the arbiter issues one access at a time
  a_rd_wr_excl: assert property (@(posedge clk) !(rd_i && wr_i));

endmodule

`default_nettype wire

// ==== serial_port.sv ====
`default_nettype none

module serial_port import soc_bus_pkg::*; #(
  parameter int SERIAL_BUSY_CYCLES = 4
) (
  input  wire logic              clk,
  input  wire logic              reset_i,
  input  wire logic              wr_i,
  input  wire logic [DATA_W-1:0] data_i,
  output logic                   done_o,
  output logic                   tx_valid_o,
  output logic [7:0]             tx_data_o
);

  localparam int CNT_W = (SERIAL_BUSY_CYCLES > 1) ? $clog2(SERIAL_BUSY_CYCLES) : 1;

  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic             tx_valid_q;
  logic [7:0]       tx_data_q;

  // busy period starts at the strobe edge, done in its last cycle
  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q     <= 1'b0;
      cnt_q      <= '0;
      tx_valid_q <= 1'b0;
    end else begin
      tx_valid_q <= wr_i;
      if (wr_i) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(SERIAL_BUSY_CYCLES - 1);
      end else if (busy_q) begin
        if (cnt_q == '0) begin
          busy_q <= 1'b0;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  // only the low byte goes out on the line
  always_ff @(posedge clk) begin
    if (wr_i) begin
      tx_data_q <= data_i[7:0];
    end
  end

  assign done_o     = busy_q && (cnt_q == '0);
  assign tx_valid_o = tx_valid_q;
  assign tx_data_o  = tx_data_q;

  a_no_wr_busy: assert property (@(posedge clk) disable iff (reset_i)
    wr_i |-> !busy_q);

endmodule

`default_nettype wire

// ==== clint_timer.sv ====
`default_nettype none

module clint_timer import soc_bus_pkg::*; (
  input  wire logic         clk,
  input  wire logic         reset_i,
  input  wire logic         rd_i,
  input  wire logic         hi_sel_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              rvalid_o
);

  logic [63:0]       mtime_q;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;

  // free-running machine time
  always_ff @(posedge clk) begin
    if (reset_i) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_i;
    end
  end

  // half select, sampled with the read strobe
  always_ff @(posedge clk) begin
    if (rd_i) begin
      rdata_q <= hi_sel_i ? mtime_q[63:32] : mtime_q[31:0];
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

`default_nettype wire

// ==== soc_bus_top.sv ====
`default_nettype none

module soc_bus_top import soc_bus_pkg::*; #(
  parameter int SRAM_WORDS         = 256,
  parameter int SERIAL_BUSY_CYCLES = 4
) (
  input  wire logic              clk,
  input  wire logic              reset_i,

  input  wire logic [ADDR_W-1:0] ifu_araddr_i,
  input  wire logic              ifu_arvalid_i,
  output logic                   ifu_arready_o,
  output logic [DATA_W-1:0]      ifu_rdata_o,
  output logic                   ifu_rvalid_o,

  input  wire logic [ADDR_W-1:0] lsu_araddr_i,
  input  wire logic              lsu_arvalid_i,
  output logic [DATA_W-1:0]      lsu_rdata_o,
  output logic                   lsu_rvalid_o,

  input  wire logic [ADDR_W-1:0] lsu_awaddr_i,
  input  wire logic              lsu_awvalid_i,
  input  wire logic [DATA_W-1:0] lsu_wdata_i,
  input  wire logic [STRB_W-1:0] lsu_wstrb_i,
  input  wire logic              lsu_wvalid_i,
  output logic                   lsu_wready_o,

  output logic                   uart_tx_valid_o,
  output logic [7:0]             uart_tx_data_o
);

  logic              sram_rd;
  logic              sram_wr;
  logic [ADDR_W-1:0] sram_addr;
  logic [DATA_W-1:0] sram_wdata;
  logic [STRB_W-1:0] sram_wstrb;
  logic [DATA_W-1:0] sram_rdata;

  logic              clint_rd;
  logic              clint_hi_sel;
  logic [DATA_W-1:0] clint_rdata;
  logic              clint_rvalid;

  logic              serial_wr;
  logic [DATA_W-1:0] serial_data;
  logic              serial_done;

  bus_arbiter u_arbiter (
    .clk            (clk),
    .reset_i        (reset_i),
    .ifu_araddr_i   (ifu_araddr_i),
    .ifu_arvalid_i  (ifu_arvalid_i),
    .ifu_arready_o  (ifu_arready_o),
    .ifu_rdata_o    (ifu_rdata_o),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_araddr_i   (lsu_araddr_i),
    .lsu_arvalid_i  (lsu_arvalid_i),
    .lsu_rdata_o    (lsu_rdata_o),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .lsu_awaddr_i   (lsu_awaddr_i),
    .lsu_awvalid_i  (lsu_awvalid_i),
    .lsu_wdata_i    (lsu_wdata_i),
    .lsu_wstrb_i    (lsu_wstrb_i),
    .lsu_wvalid_i   (lsu_wvalid_i),
    .lsu_wready_o   (lsu_wready_o),
    .sram_rd_o      (sram_rd),
    .sram_wr_o      (sram_wr),
    .sram_addr_o    (sram_addr),
    .sram_wdata_o   (sram_wdata),
    .sram_wstrb_o   (sram_wstrb),
    .sram_rdata_i   (sram_rdata),
    .clint_rd_o     (clint_rd),
    .clint_hi_sel_o (clint_hi_sel),
    .clint_rdata_i  (clint_rdata),
    .clint_rvalid_i (clint_rvalid),
    .serial_wr_o    (serial_wr),
    .serial_data_o  (serial_data),
    .serial_done_i  (serial_done)
  );

  mem_sram #(
    .SRAM_WORDS (SRAM_WORDS)
  ) u_sram (
    .clk     (clk),
    .rd_i    (sram_rd),
    .wr_i    (sram_wr),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .wstrb_i (sram_wstrb),
    .rdata_o (sram_rdata)
  );

  serial_port #(
    .SERIAL_BUSY_CYCLES (SERIAL_BUSY_CYCLES)
  ) u_serial (
    .clk        (clk),
    .reset_i    (reset_i),
    .wr_i       (serial_wr),
    .data_i     (serial_data),
    .done_o     (serial_done),
    .tx_valid_o (uart_tx_valid_o),
    .tx_data_o  (uart_tx_data_o)
  );

  clint_timer u_clint (
    .clk      (clk),
    .reset_i  (reset_i),
    .rd_i     (clint_rd),
    .hi_sel_i (clint_hi_sel),
    .rdata_o  (clint_rdata),
    .rvalid_o (clint_rvalid)
  );

endmodule

`default_nettype wire

// ==== tb_bus_checker.sv ====
`default_nettype none

module tb_bus_checker import soc_bus_pkg::*; #(
  parameter int SRAM_WORDS = 256
) (
  input  wire logic              clk,
  input  wire logic              reset_i,
  input  wire logic [ADDR_W-1:0] ifu_araddr_i,
  input  wire logic              ifu_arvalid_i,
  input  wire logic              ifu_arready_i,
  input  wire logic [DATA_W-1:0] ifu_rdata_i,
  input  wire logic              ifu_rvalid_i,
  input  wire logic [ADDR_W-1:0] lsu_araddr_i,
  input  wire logic              lsu_arvalid_i,
  input  wire logic [DATA_W-1:0] lsu_rdata_i,
  input  wire logic              lsu_rvalid_i,
  input  wire logic [ADDR_W-1:0] lsu_awaddr_i,
  input  wire logic              lsu_awvalid_i,
  input  wire logic [DATA_W-1:0] lsu_wdata_i,
  input  wire logic [STRB_W-1:0] lsu_wstrb_i,
  input  wire logic              lsu_wvalid_i,
  input  wire logic              lsu_wready_i,
  input  wire logic              tx_valid_i,
  input  wire logic [7:0]        tx_data_i,
  output int                     errors_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [DATA_W-1:0] ref_mem [SRAM_WORDS];
  logic [7:0]        serial_q [$];
  logic [7:0]        exp_byte;
  logic              ser_open = 1'b0;
  int                ser_bytes = 0;
  logic              seen_req = 1'b0;
  logic              ifu_granted = 1'b0;
  logic              lo_seen = 1'b0;
  logic              hi_grew = 1'b0;
  logic [DATA_W-1:0] last_lo = '0;
  logic [DATA_W-1:0] last_hi = '0;
  logic [63:0]       elapsed = '0;
  int                errors = 0;

  // sram word index wrapped to the depth
  function automatic int word_index(input logic [ADDR_W-1:0] addr);
    return int'((addr >> 2) % SRAM_WORDS);
  endfunction

  // expected word after a byte-masked store
  function automatic logic [DATA_W-1:0] merge_store(input logic [DATA_W-1:0] old,
                                                    input logic [DATA_W-1:0] data,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Error at time %0t: %s", $time, msg);
  endtask

  // samples the values that were settled before each rising edge
  always @(posedge clk) begin
    if (!reset_i) begin
      if (!seen_req && (ifu_arready_i || ifu_rvalid_i || lsu_rvalid_i ||
                        lsu_wready_i || tx_valid_i)) begin
        report_mismatch("response strobe before any request");
      end
      if (ifu_arvalid_i || lsu_arvalid_i || lsu_awvalid_i) begin
        seen_req = 1'b1;
      end

      // a fetch is granted by ifu_arready one cycle before its data
      if (ifu_arready_i && !ifu_arvalid_i) begin
        report_mismatch("ifu_arready with no fetch pending");
      end
      if (ifu_rvalid_i && !ifu_granted) begin
        report_mismatch("ifu_rvalid without ifu_arready in the cycle before");
      end
      ifu_granted = ifu_arready_i;

      if (ifu_rvalid_i && ifu_rdata_i !== ref_mem[word_index(ifu_araddr_i)]) begin
        report_mismatch($sformatf("ifu read %h gave %h, expected %h", ifu_araddr_i,
                                  ifu_rdata_i, ref_mem[word_index(ifu_araddr_i)]));
      end

      if (lsu_rvalid_i) begin
        if (lsu_araddr_i == RTC_ADDR_HI) begin
          // mtime starts at 0 and cannot run ahead of the cycles since reset
          if (lsu_rdata_i > elapsed[63:32]) begin
            report_mismatch($sformatf("mtime high %h ahead of %0d cycles since reset",
                                      lsu_rdata_i, elapsed));
          end
          // high word must never go backwards
          if (lsu_rdata_i < last_hi) begin
            report_mismatch($sformatf("mtime high fell from %h to %h", last_hi, lsu_rdata_i));
          end else if (lsu_rdata_i > last_hi) begin
            hi_grew = 1'b1;
          end
          last_hi = lsu_rdata_i;
        end else if (lsu_araddr_i == RTC_ADDR_LO) begin
          if (elapsed[63:32] == '0 && lsu_rdata_i > elapsed[31:0]) begin
            report_mismatch($sformatf("mtime low %h ahead of %0d cycles since reset",
                                      lsu_rdata_i, elapsed));
          end
          if (lo_seen && !(lsu_rdata_i > last_lo || hi_grew)) begin
            report_mismatch($sformatf("mtime low %h not above %h", lsu_rdata_i, last_lo));
          end
          lo_seen = 1'b1;
          hi_grew = 1'b0;
          last_lo = lsu_rdata_i;
        end else if (lsu_rdata_i !== ref_mem[word_index(lsu_araddr_i)]) begin
          report_mismatch($sformatf("lsu load %h gave %h, expected %h", lsu_araddr_i,
                                    lsu_rdata_i, ref_mem[word_index(lsu_araddr_i)]));
        end
      end

      if (tx_valid_i) begin
        ser_bytes++;
        if (serial_q.size() == 0) begin
          report_mismatch($sformatf("serial byte %h with no store pending", tx_data_i));
        end else begin
          exp_byte = serial_q.pop_front();
          if (tx_data_i !== exp_byte) begin
            report_mismatch($sformatf("serial byte %h, expected %h", tx_data_i, exp_byte));
          end
        end
      end

      if (lsu_wready_i) begin
        if (lsu_awaddr_i == SERIAL_ADDR) begin
          if (ser_bytes != 1) begin
            report_mismatch($sformatf("serial store sent %0d bytes", ser_bytes));
          end
          ser_open = 1'b0;
        end else begin
          ref_mem[word_index(lsu_awaddr_i)] = merge_store(ref_mem[word_index(lsu_awaddr_i)],
                                                          lsu_wdata_i, lsu_wstrb_i);
        end
      end else if (lsu_awvalid_i && lsu_wvalid_i && lsu_awaddr_i == SERIAL_ADDR &&
                   !ser_open) begin
        // a new serial store expects one byte on the line
        serial_q.push_back(lsu_wdata_i[7:0]);
        ser_open = 1'b1;
        ser_bytes = 0;
      end

      elapsed = elapsed + 64'd1;
    end
  end

  assign errors_o = errors;

endmodule

`default_nettype wire

// ==== tb_soc_bus.sv ====
`default_nettype none

module tb_soc_bus import soc_bus_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SRAM_WORDS         = 256;
  localparam int SERIAL_BUSY_CYCLES = 4;
  localparam int TEST_WORDS         = 16;
  localparam int WAIT_LIMIT         = 50;
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h0000_1000;
  // sram word with the same index as SERIAL_ADDR
  localparam logic [ADDR_W-1:0] SERIAL_ALIAS =
    SRAM_BASE + ADDR_W'(((SERIAL_ADDR >> 2) % SRAM_WORDS) << 2);

  logic              clk;
  logic              reset;
  logic [ADDR_W-1:0] ifu_araddr;
  logic              ifu_arvalid;
  logic              ifu_arready;
  logic [DATA_W-1:0] ifu_rdata;
  logic              ifu_rvalid;
  logic [ADDR_W-1:0] lsu_araddr;
  logic              lsu_arvalid;
  logic [DATA_W-1:0] lsu_rdata;
  logic              lsu_rvalid;
  logic [ADDR_W-1:0] lsu_awaddr;
  logic              lsu_awvalid;
  logic [DATA_W-1:0] lsu_wdata;
  logic [STRB_W-1:0] lsu_wstrb;
  logic              lsu_wvalid;
  logic              lsu_wready;
  logic              tx_valid;
  logic [7:0]        tx_data;
  logic [31:0]       lfsr_q;
  int                chk_errors;
  int                drv_errors;

  soc_bus_top #(
    .SRAM_WORDS         (SRAM_WORDS),
    .SERIAL_BUSY_CYCLES (SERIAL_BUSY_CYCLES)
  ) UUT (
    .clk (clk), .reset_i (reset),
    .ifu_araddr_i (ifu_araddr), .ifu_arvalid_i (ifu_arvalid), .ifu_arready_o (ifu_arready),
    .ifu_rdata_o (ifu_rdata), .ifu_rvalid_o (ifu_rvalid),
    .lsu_araddr_i (lsu_araddr), .lsu_arvalid_i (lsu_arvalid),
    .lsu_rdata_o (lsu_rdata), .lsu_rvalid_o (lsu_rvalid),
    .lsu_awaddr_i (lsu_awaddr), .lsu_awvalid_i (lsu_awvalid), .lsu_wdata_i (lsu_wdata),
    .lsu_wstrb_i (lsu_wstrb), .lsu_wvalid_i (lsu_wvalid), .lsu_wready_o (lsu_wready),
    .uart_tx_valid_o (tx_valid), .uart_tx_data_o (tx_data)
  );

  tb_bus_checker #(
    .SRAM_WORDS (SRAM_WORDS)
  ) u_checker (
    .clk (clk), .reset_i (reset),
    .ifu_araddr_i (ifu_araddr), .ifu_arvalid_i (ifu_arvalid), .ifu_arready_i (ifu_arready),
    .ifu_rdata_i (ifu_rdata), .ifu_rvalid_i (ifu_rvalid),
    .lsu_araddr_i (lsu_araddr), .lsu_arvalid_i (lsu_arvalid),
    .lsu_rdata_i (lsu_rdata), .lsu_rvalid_i (lsu_rvalid),
    .lsu_awaddr_i (lsu_awaddr), .lsu_awvalid_i (lsu_awvalid), .lsu_wdata_i (lsu_wdata),
    .lsu_wstrb_i (lsu_wstrb), .lsu_wvalid_i (lsu_wvalid), .lsu_wready_i (lsu_wready),
    .tx_valid_i (tx_valid), .tx_data_i (tx_data), .errors_o (chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois lfsr stepped once per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lsb    = lfsr_q[0];
      lfsr_q = (lfsr_q >> 1) ^ (lsb ? 32'h8020_0003 : 32'h0);
      val    = {val[30:0], lsb};
    end
    return val;
  endfunction

  function automatic logic [ADDR_W-1:0] word_addr(input int w);
    return SRAM_BASE + ADDR_W'(w << 2);
  endfunction

  task automatic lsu_store(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb);
    int n;
    lsu_awaddr  = addr;
    lsu_wdata   = data;
    lsu_wstrb   = strb;
    lsu_awvalid = 1'b1;
    lsu_wvalid  = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!lsu_wready && n < WAIT_LIMIT);
    if (!lsu_wready) begin
      $display("timeout: store to %h got no lsu_wready", addr);
      drv_errors++;
    end
    lsu_awvalid = 1'b0;
    lsu_wvalid  = 1'b0;
    // address and data stay put until the write edge has passed
    @(negedge clk);
  endtask

  task automatic lsu_load(input logic [ADDR_W-1:0] addr);
    int n;
    lsu_araddr  = addr;
    lsu_arvalid = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!lsu_rvalid && n < WAIT_LIMIT);
    if (!lsu_rvalid) begin
      $display("timeout: load from %h got no lsu_rvalid", addr);
      drv_errors++;
    end
    lsu_arvalid = 1'b0;
    @(negedge clk);
  endtask

  task automatic ifu_fetch(input logic [ADDR_W-1:0] addr);
    int n;
    ifu_araddr  = addr;
    ifu_arvalid = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ifu_rvalid && n < WAIT_LIMIT);
    if (!ifu_rvalid) begin
      $display("timeout: fetch from %h got no ifu_rvalid", addr);
      drv_errors++;
    end
    ifu_arvalid = 1'b0;
    @(negedge clk);
  endtask

  // both requesters in the same cycle and the lsu must be served first
  task automatic fetch_and_load(input logic [ADDR_W-1:0] iaddr,
                                input logic [ADDR_W-1:0] laddr);
    int   n;
    logic lsu_seen;
    logic ifu_seen;
    logic ifu_first;
    ifu_araddr  = iaddr;
    lsu_araddr  = laddr;
    ifu_arvalid = 1'b1;
    lsu_arvalid = 1'b1;
    n = 0;
    lsu_seen  = 1'b0;
    ifu_seen  = 1'b0;
    ifu_first = 1'b0;
    while (!(lsu_seen && ifu_seen) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
      if (lsu_rvalid) begin
        lsu_seen    = 1'b1;
        lsu_arvalid = 1'b0;
      end
      if (ifu_rvalid) begin
        ifu_first   = !lsu_seen;
        ifu_seen    = 1'b1;
        ifu_arvalid = 1'b0;
      end
    end
    if (!(lsu_seen && ifu_seen)) begin
      $display("timeout: concurrent fetch and load did not both complete");
      drv_errors++;
    end
    if (ifu_first) begin
      $display("the ifu was answered before the lsu in a same-cycle request");
      drv_errors++;
    end
    ifu_arvalid = 1'b0;
    lsu_arvalid = 1'b0;
    @(negedge clk);
  endtask

  initial begin
    int                w;
    logic [DATA_W-1:0] d;
    logic [STRB_W-1:0] s;
    reset       = 1'b1;
    ifu_araddr  = '0;
    ifu_arvalid = 1'b0;
    lsu_araddr  = '0;
    lsu_arvalid = 1'b0;
    lsu_awaddr  = '0;
    lsu_awvalid = 1'b0;
    lsu_wdata   = '0;
    lsu_wstrb   = '0;
    lsu_wvalid  = 1'b0;
    lfsr_q      = 32'd40;
    drv_errors  = 0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    // quiet stretch that the checker watches for stray strobes
    repeat (5) @(negedge clk);

    // full words first so partial stores merge into known bytes
    for (int i = 0; i < TEST_WORDS; i++) begin
      d = take_bits(DATA_W);
      lsu_store(word_addr(i), d, '1);
    end
    for (int i = 0; i < 40; i++) begin
      w = int'(take_bits(4));
      d = take_bits(DATA_W);
      s = STRB_W'(take_bits(STRB_W));
      lsu_store(word_addr(w), d, s);
      lsu_load(word_addr(w));
    end

    for (int i = 0; i < 16; i++) begin
      ifu_fetch(word_addr(int'(take_bits(4))));
    end
    for (int i = 0; i < 8; i++) begin
      w = int'(take_bits(4));
      fetch_and_load(word_addr(w), word_addr(int'(take_bits(4))));
    end

    // known contents in the word a misdecoded serial store would hit
    d = take_bits(DATA_W);
    lsu_store(SERIAL_ALIAS, d, '1);
    for (int i = 0; i < 6; i++) begin
      d = take_bits(DATA_W);
      s = STRB_W'(take_bits(STRB_W));
      lsu_store(SERIAL_ADDR, d, s);
    end
    // sram must be untouched by the serial stores
    for (int i = 0; i < TEST_WORDS; i++) begin
      lsu_load(word_addr(i));
    end
    lsu_load(SERIAL_ALIAS);

    for (int i = 0; i < 4; i++) begin
      lsu_load(RTC_ADDR_LO);
      lsu_load(RTC_ADDR_HI);
      lsu_load(RTC_ADDR_LO);
    end

    repeat (5) @(negedge clk);
    $display("error count: checker %0d, testbench %0d", chk_errors, drv_errors);
    if (chk_errors == 0 && drv_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
soc_bus_pkg.sv
bus_arbiter.sv
mem_sram.sv
serial_port.sv
clint_timer.sv
soc_bus_top.sv
tb_bus_checker.sv
tb_soc_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module tb_soc_bus \
  -f sim.f \
  -o tb_soc_bus

./obj_dir/tb_soc_bus | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
